/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_top_fb_dvi
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir

BIN   := $(OBJ_DIR)/V$(TOP)
SRCS  := $(shell grep -v '^+' $(FILELIST))
TRACE := tests/video_trace.txt

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN) $(TRACE)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

/* hw/dvi_channel_mux.sv */
`timescale 1ns/100ps

module dvi_channel_mux (
    input  logic                                    i_clk_pixel,
    input  logic                                    i_arst_n,
    input  logic                                    i_hsync,
    input  logic                                    i_vsync,
    input  logic                                    i_data_en,
    input  logic [video_timing_pkg::color_width-1:0] i_data [tmds_pkg::tmds_channels],
    output logic [video_timing_pkg::color_width-1:0] o_chan_data [tmds_pkg::tmds_channels],
    output logic                                    o_chan_de,
    output logic [1:0]                              o_chan_ctrl [tmds_pkg::tmds_channels]
);
    import tmds_pkg::*;

    // timing signals one cycle late, in step with the buffer read data.
    logic hsync_d;
    logic vsync_d;
    logic de_d;

    always_ff @(posedge i_clk_pixel or negedge i_arst_n) begin
        if (!i_arst_n) begin
            hsync_d   <= 1'b0;
            vsync_d   <= 1'b0;
            de_d      <= 1'b0;
            o_chan_de <= 1'b0;
            for (int c = 0; c < tmds_channels; c++) begin
                o_chan_ctrl[c] <= 2'b00;
            end
        end else begin
            hsync_d   <= i_hsync;
            vsync_d   <= i_vsync;
            de_d      <= i_data_en;
            o_chan_de <= de_d;
            // only blue carries the syncs.
            for (int c = 0; c < tmds_channels; c++) begin
                o_chan_ctrl[c] <= (c == 0) ? {vsync_d, hsync_d} : 2'b00;
            end
        end
    end

    // colour is zeroed outside the active area.
    always_ff @(posedge i_clk_pixel) begin
        for (int c = 0; c < tmds_channels; c++) begin
            o_chan_data[c] <= de_d ? i_data[c] : '0;
        end
    end

endmodule

/* hw/framebuffer.sv */
`timescale 1ns/100ps

module framebuffer (
    input  logic                                                 i_clk_pixel,
    input  logic                                                 i_arst_n,
    input  logic                                                 i_wr_en,
    input  logic [video_timing_pkg::fb_addr_width-1:0]           i_wr_addr,
    input  logic [video_timing_pkg::color_width*tmds_pkg::tmds_channels-1:0] i_wr_data,
    input  logic signed [video_timing_pkg::pos_width-1:0]        i_x_pos,
    input  logic signed [video_timing_pkg::pos_width-1:0]        i_y_pos,
    output logic [video_timing_pkg::color_width-1:0]             o_data [tmds_pkg::tmds_channels]
);
    import video_timing_pkg::*;
    import tmds_pkg::*;

    // blue in the low byte, red in the high byte.
    logic [color_width*tmds_channels-1:0] mem [2**fb_addr_width];
    logic [fb_addr_width-1:0]             rd_addr;
    logic                                 in_area;

    // blanking positions fall back to entry 0.
    always_comb begin
        in_area = (i_x_pos >= 0) && (i_x_pos < h_active) &&
                  (i_y_pos >= 0) && (i_y_pos < v_active);
        rd_addr = in_area ? fb_addr_width'(i_y_pos) * fb_addr_width'(h_active) +
                            fb_addr_width'(i_x_pos) : '0;
    end

    always_ff @(posedge i_clk_pixel) begin
        if (i_wr_en) begin
            mem[i_wr_addr] <= i_wr_data;
        end
    end

    // read before write on a shared address.
    always_ff @(posedge i_clk_pixel or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int c = 0; c < tmds_channels; c++) begin
                o_data[c] <= '0;
            end
        end else begin
            for (int c = 0; c < tmds_channels; c++) begin
                o_data[c] <= mem[rd_addr][c*color_width +: color_width];
            end
        end
    end

endmodule

/* hw/tmds_encoder.sv */
`timescale 1ns/100ps

module tmds_encoder (
    input  logic                            i_clk_pixel,
    input  logic                            i_arst_n,
    input  logic                            i_de,
    input  logic [7:0]                      i_data,
    input  logic [1:0]                      i_ctrl,
    output logic [tmds_pkg::tmds_width-1:0] o_symbol
);
    import tmds_pkg::*;

    logic [3:0]                        ones_data;
    logic [3:0]                        ones_qm;
    logic                              use_xnor;
    logic [8:0]                        q_m;
    logic signed [tmds_disp_width-1:0] balance;
    logic signed [tmds_disp_width-1:0] disparity;
    logic signed [tmds_disp_width-1:0] disparity_next;
    logic [tmds_width-1:0]             data_sym;
    logic [tmds_width-1:0]             ctrl_sym;

    // transition minimizing stage, q_m[8] tells xor from xnor.
    always_comb begin
        ones_data = '0;
        for (int i = 0; i < 8; i++) begin
            ones_data = ones_data + 4'(i_data[i]);
        end
        use_xnor = (ones_data > 4'd4) || ((ones_data == 4'd4) && !i_data[0]);
        q_m[0] = i_data[0];
        for (int i = 1; i < 8; i++) begin
            q_m[i] = use_xnor ? ~(q_m[i-1] ^ i_data[i]) : (q_m[i-1] ^ i_data[i]);
        end
        q_m[8] = !use_xnor;
    end

    // dc balancing stage.
    always_comb begin
        ones_qm = '0;
        for (int i = 0; i < 8; i++) begin
            ones_qm = ones_qm + 4'(q_m[i]);
        end
        // ones minus zeros in the low byte.
        balance = $signed(tmds_disp_width'({ones_qm, 1'b0})) - tmds_disp_width'(8);

        if ((disparity == 0) || (balance == 0)) begin
            data_sym       = {~q_m[8], q_m[8], q_m[8] ? q_m[7:0] : ~q_m[7:0]};
            disparity_next = q_m[8] ? disparity + balance : disparity - balance;
        end else if (((disparity > 0) && (balance > 0)) ||
                     ((disparity < 0) && (balance < 0))) begin
            data_sym       = {1'b1, q_m[8], ~q_m[7:0]};
            disparity_next = disparity - balance +
                             (q_m[8] ? tmds_disp_width'(2) : tmds_disp_width'(0));
        end else begin
            data_sym       = {1'b0, q_m[8], q_m[7:0]};
            disparity_next = disparity + balance -
                             (q_m[8] ? tmds_disp_width'(0) : tmds_disp_width'(2));
        end
    end

    always_comb begin
        case (i_ctrl)
            2'b00:   ctrl_sym = ctrl_sym_00;
            2'b01:   ctrl_sym = ctrl_sym_01;
            2'b10:   ctrl_sym = ctrl_sym_10;
            default: ctrl_sym = ctrl_sym_11;
        endcase
    end

    // blanking restarts the disparity from zero.
    always_ff @(posedge i_clk_pixel or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_symbol  <= ctrl_sym_00;
            disparity <= '0;
        end else if (i_de) begin
            o_symbol  <= data_sym;
            disparity <= disparity_next;
        end else begin
            o_symbol  <= ctrl_sym;
            disparity <= '0;
        end
    end

endmodule

/* hw/tmds_pkg.sv */
package tmds_pkg;

    localparam int tmds_width  = 10;

    // channel 0 is blue, 1 is green, 2 is red.
    localparam int tmds_channels = 3;

    // mod-10 bit phase and running disparity.
    localparam int tmds_phase_width = 4;
    localparam int tmds_disp_width  = 6;

    // control symbols, indexed by {c1, c0}.
    localparam logic [tmds_width-1:0] ctrl_sym_00 = 10'b1101010100;
    localparam logic [tmds_width-1:0] ctrl_sym_01 = 10'b0010101011;
    localparam logic [tmds_width-1:0] ctrl_sym_10 = 10'b0101010100;
    localparam logic [tmds_width-1:0] ctrl_sym_11 = 10'b1010101011;

    // sent lsb first: five ones, then five zeros.
    localparam logic [tmds_width-1:0] tmds_clk_pattern = 10'b0000011111;

endpackage

/* hw/tmds_serializer.sv */
`timescale 1ns/100ps

module tmds_serializer (
    input  logic                               i_clk_shift,
    input  logic                               i_arst_n,
    input  logic [tmds_pkg::tmds_width-1:0]    i_symbols [tmds_pkg::tmds_channels],
    output logic [tmds_pkg::tmds_channels-1:0] o_tmds_data,
    output logic                               o_tmds_clk
);
    import tmds_pkg::*;

    logic [tmds_phase_width-1:0] phase;
    logic [tmds_width-1:0]       shift_data [tmds_channels];
    logic [tmds_width-1:0]       shift_clk;

    // the phase counter leaves reset on the shift edge that lines up
    // with a pixel edge, so every load falls on a pixel boundary.
    always_ff @(posedge i_clk_shift or negedge i_arst_n) begin
        if (!i_arst_n) begin
            phase <= '0;
        end else if (phase == tmds_phase_width'(tmds_width - 1)) begin
            phase <= '0;
        end else begin
            phase <= phase + 1'b1;
        end
    end

    // load all four words together, then shift them out lsb first.
    always_ff @(posedge i_clk_shift or negedge i_arst_n) begin
        if (!i_arst_n) begin
            shift_clk <= tmds_clk_pattern;
            for (int c = 0; c < tmds_channels; c++) begin
                shift_data[c] <= ctrl_sym_00;
            end
        end else if (phase == '0) begin
            shift_clk <= tmds_clk_pattern;
            for (int c = 0; c < tmds_channels; c++) begin
                shift_data[c] <= i_symbols[c];
            end
        end else begin
            shift_clk <= {1'b0, shift_clk[tmds_width-1:1]};
            for (int c = 0; c < tmds_channels; c++) begin
                shift_data[c] <= {1'b0, shift_data[c][tmds_width-1:1]};
            end
        end
    end

    always_comb begin
        o_tmds_clk = shift_clk[0];
        for (int c = 0; c < tmds_channels; c++) begin
            o_tmds_data[c] = shift_data[c][0];
        end
    end

endmodule

/* hw/top_fb_dvi.sv */
`timescale 1ns/100ps

module top_fb_dvi (
    input  logic                                                      i_clk_pixel,
    input  logic                                                      i_clk_shift,
    input  logic                                                      i_arst_n,
    input  logic                                                      i_wr_en,
    input  logic [video_timing_pkg::fb_addr_width-1:0]                i_wr_addr,
    input  logic [video_timing_pkg::color_width*tmds_pkg::tmds_channels-1:0] i_wr_data,
    output logic [tmds_pkg::tmds_channels-1:0]                        o_tmds_data,
    output logic                                                      o_tmds_clk,
    output logic                                                      o_frame
);
    import video_timing_pkg::*;
    import tmds_pkg::*;

    logic                        s_hsync;
    logic                        s_vsync;
    logic                        s_de;
    logic signed [pos_width-1:0] s_x_pos;
    logic signed [pos_width-1:0] s_y_pos;
    logic [color_width-1:0]      s_colors [tmds_channels];
    logic [color_width-1:0]      s_chan_data [tmds_channels];
    logic                        s_chan_de;
    logic [1:0]                  s_chan_ctrl [tmds_channels];
    logic [tmds_width-1:0]       s_symbols [tmds_channels];

    vga_gen inst_vga_gen (
        .i_clk_pixel (i_clk_pixel),
        .i_arst_n    (i_arst_n),
        .o_hsync     (s_hsync),
        .o_vsync     (s_vsync),
        .o_data_en   (s_de),
        .o_frame     (o_frame),
        .o_line      (),
        .o_x_pos     (s_x_pos),
        .o_y_pos     (s_y_pos)
    );

    framebuffer inst_framebuffer (
        .i_clk_pixel (i_clk_pixel),
        .i_arst_n    (i_arst_n),
        .i_wr_en     (i_wr_en),
        .i_wr_addr   (i_wr_addr),
        .i_wr_data   (i_wr_data),
        .i_x_pos     (s_x_pos),
        .i_y_pos     (s_y_pos),
        .o_data      (s_colors)
    );

    dvi_channel_mux inst_channel_mux (
        .i_clk_pixel (i_clk_pixel),
        .i_arst_n    (i_arst_n),
        .i_hsync     (s_hsync),
        .i_vsync     (s_vsync),
        .i_data_en   (s_de),
        .i_data      (s_colors),
        .o_chan_data (s_chan_data),
        .o_chan_de   (s_chan_de),
        .o_chan_ctrl (s_chan_ctrl)
    );

    // one encoder per colour channel.
    for (genvar c = 0; c < tmds_channels; c++) begin : g_enc
        tmds_encoder inst_encoder (
            .i_clk_pixel (i_clk_pixel),
            .i_arst_n    (i_arst_n),
            .i_de        (s_chan_de),
            .i_data      (s_chan_data[c]),
            .i_ctrl      (s_chan_ctrl[c]),
            .o_symbol    (s_symbols[c])
        );
    end

    tmds_serializer inst_serializer (
        .i_clk_shift (i_clk_shift),
        .i_arst_n    (i_arst_n),
        .i_symbols   (s_symbols),
        .o_tmds_data (o_tmds_data),
        .o_tmds_clk  (o_tmds_clk)
    );

endmodule

/* hw/vga_gen.sv */
`timescale 1ns/100ps

module vga_gen (
    input  logic                                          i_clk_pixel,
    input  logic                                          i_arst_n,
    output logic                                          o_hsync,
    output logic                                          o_vsync,
    output logic                                          o_data_en,
    output logic                                          o_frame,
    output logic                                          o_line,
    output logic signed [video_timing_pkg::pos_width-1:0] o_x_pos,
    output logic signed [video_timing_pkg::pos_width-1:0] o_y_pos
);
    import video_timing_pkg::*;

    logic signed [pos_width-1:0] h_cnt;
    logic signed [pos_width-1:0] v_cnt;

    // raster counters.
    always_ff @(posedge i_clk_pixel or negedge i_arst_n) begin
        if (!i_arst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == h_total - 1) begin
            h_cnt <= '0;
            if (v_cnt == v_total - 1) begin
                v_cnt <= '0;
            end else begin
                v_cnt <= v_cnt + pos_width'(1);
            end
        end else begin
            h_cnt <= h_cnt + pos_width'(1);
        end
    end

    // all outputs are decoded from the same counter state, so they stay aligned.
    always_ff @(posedge i_clk_pixel or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_x_pos   <= '0;
            o_y_pos   <= '0;
            o_data_en <= 1'b0;
            o_hsync   <= 1'b0;
            o_vsync   <= 1'b0;
            o_line    <= 1'b0;
            o_frame   <= 1'b0;
        end else begin
            o_x_pos   <= h_cnt;
            o_y_pos   <= v_cnt;
            o_data_en <= (h_cnt < h_active) && (v_cnt < v_active);
            o_hsync   <= (h_cnt >= h_active + h_front) &&
                         (h_cnt < h_active + h_front + h_sync);
            o_vsync   <= (v_cnt >= v_active + v_front) &&
                         (v_cnt < v_active + v_front + v_sync);
            o_line    <= (h_cnt == 0);
            o_frame   <= (h_cnt == 0) && (v_cnt == 0);
        end
    end

endmodule

/* hw/video_timing_pkg.sv */
package video_timing_pkg;

    // reduced test mode, one pixel per clock.
    localparam int h_active = 16;
    localparam int h_front  = 2;
    localparam int h_sync   = 4;
    localparam int h_back   = 2;
    localparam int h_total  = h_active + h_front + h_sync + h_back;

    localparam int v_active = 8;
    localparam int v_front  = 1;
    localparam int v_sync   = 2;
    localparam int v_back   = 1;
    localparam int v_total  = v_active + v_front + v_sync + v_back;

    // signed raster position, syncs are active high.
    localparam int pos_width = 16;

    // one entry per active pixel.
    localparam int fb_addr_width = 7;
    localparam int color_width   = 8;

endpackage

/* tests/tb_top_fb_dvi.sv */
`timescale 1ns/100ps

module tb_top_fb_dvi;
    import video_timing_pkg::*;

    localparam int frame_cycles = h_total * v_total;
    // pixel clocks from the frame edge to the first bit of position 0.
    localparam int word_latency = 4;
    // a word starts on a pixel edge and is sampled half a bit later.
    localparam int pixel_period   = 100;
    localparam int bit_sample_ofs = 5;
    localparam logic [9:0] clk_word = 10'b0000011111;
    localparam logic [9:0] sym_c00  = 10'b1101010100;
    localparam logic [9:0] sym_c01  = 10'b0010101011;
    localparam logic [9:0] sym_c10  = 10'b0101010100;
    localparam logic [9:0] sym_c11  = 10'b1010101011;

    logic                         clk_pixel;
    logic                         clk_shift;
    logic                         arst_n;
    logic                         wr_en;
    logic [fb_addr_width-1:0]     wr_addr;
    logic [3*color_width-1:0]     wr_data;
    logic [2:0]                   tmds_data;
    logic                         tmds_clk;
    logic                         frame;

    int          frame_idx = -1;
    int          pix_cnt = 0;
    logic [29:0] exp_sym [3][128];
    bit          has_exp [3][128];
    int          n_exp = 0;
    int          n_seen = 0;
    int          wr_tag_q [$];
    int          wr_addr_q [$];
    logic [23:0] wr_data_q [$];

    logic        prev_clk = 1'b1;
    bit          locked = 1'b0;
    int          bit_cnt = 0;
    int          word_f = 0;
    int          word_p = 0;
    logic [9:0]  word_b;
    logic [9:0]  word_g;
    logic [9:0]  word_r;
    logic [9:0]  word_c;

    top_fb_dvi UUT (
        .i_clk_pixel (clk_pixel),
        .i_clk_shift (clk_shift),
        .i_arst_n    (arst_n),
        .i_wr_en     (wr_en),
        .i_wr_addr   (wr_addr),
        .i_wr_data   (wr_data),
        .o_tmds_data (tmds_data),
        .o_tmds_clk  (tmds_clk),
        .o_frame     (frame)
    );

    // both clocks rise together every pixel period.
    initial begin
        clk_pixel = 1'b1;
        forever #50 clk_pixel = ~clk_pixel;
    end

    initial begin
        clk_shift = 1'b1;
        forever #5 clk_shift = ~clk_shift;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERROR: %s expected %0h actual %0h", name, expected, actual);
            $display("STATUS: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "run aborted");
    endtask

    function automatic logic [9:0] ctrl_for(input int x, input int y);
        logic hs;
        logic vs;
        hs = (x >= h_active + h_front) && (x < h_active + h_front + h_sync);
        vs = (y >= v_active + v_front) && (y < v_active + v_front + v_sync);
        case ({vs, hs})
            2'b00:   return sym_c00;
            2'b01:   return sym_c01;
            2'b10:   return sym_c10;
            default: return sym_c11;
        endcase
    endfunction

    task automatic read_trace;
        int          fd;
        int          n;
        int          tag;
        int          addr;
        int          f;
        int          x;
        int          y;
        logic [23:0] rgb;
        logic [9:0]  b;
        logic [9:0]  g;
        logic [9:0]  r;
        string       line;
        fd = $fopen("tests/video_trace.txt", "r");
        if (fd == 0) begin
            abort_run("could not open the trace file tests/video_trace.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 0) begin
                if (line[0] == "W") begin
                    n = $sscanf(line, "W %d %d %h", tag, addr, rgb);
                    if (n != 3) begin
                        abort_run("a write line in the trace is malformed");
                    end
                    wr_tag_q.push_back(tag);
                    wr_addr_q.push_back(addr);
                    wr_data_q.push_back(rgb);
                end else if (line[0] == "E") begin
                    n = $sscanf(line, "E %d %d %d %h %h %h", f, x, y, b, g, r);
                    if (n != 6) begin
                        abort_run("an expect line in the trace is malformed");
                    end
                    exp_sym[f][y*h_active+x] = {r, g, b};
                    has_exp[f][y*h_active+x] = 1'b1;
                    n_exp++;
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic issue_writes(input int tag);
        for (int i = 0; i < wr_tag_q.size(); i++) begin
            if (wr_tag_q[i] == tag) begin
                @(negedge clk_pixel);
                wr_en   = 1'b1;
                wr_addr = fb_addr_width'(wr_addr_q[i]);
                wr_data = wr_data_q[i];
            end
        end
        @(negedge clk_pixel);
        wr_en = 1'b0;
    endtask

    task automatic wait_for_lock;
        int t;
        t = 0;
        while (!locked && t < 200) begin
            @(posedge clk_shift);
            t++;
        end
        if (!locked) begin
            abort_run("timed out waiting for the clock channel word alignment");
        end
    endtask

    task automatic wait_for_frame(input int n);
        int t;
        t = 0;
        while (frame_idx < n && t < 2 * frame_cycles) begin
            @(negedge clk_pixel);
            t++;
        end
        if (frame_idx < n) begin
            abort_run("timed out waiting for the frame strobe");
        end
    endtask

    task automatic wait_for_pix(input int pos);
        int t;
        t = 0;
        while (pix_cnt < pos && t < frame_cycles) begin
            @(negedge clk_pixel);
            t++;
        end
        if (pix_cnt < pos) begin
            abort_run("timed out waiting for the raster position");
        end
    endtask

    task automatic check_word;
        int    x;
        int    y;
        string pos;
        x = word_p % h_total;
        y = word_p / h_total;
        pos = $sformatf("frame %0d x %0d y %0d", word_f, x, y);
        check_value({pos, " clock word"}, 32'(clk_word), 32'(word_c));
        if (word_f >= 1 && word_f <= 2) begin
            if (x >= h_active || y >= v_active) begin
                check_value({pos, " blue control"}, 32'(ctrl_for(x, y)), 32'(word_b));
                check_value({pos, " green control"}, 32'(sym_c00), 32'(word_g));
                check_value({pos, " red control"}, 32'(sym_c00), 32'(word_r));
            end else if (has_exp[word_f][y*h_active+x]) begin
                check_value({pos, " blue pixel"},
                            32'(exp_sym[word_f][y*h_active+x][9:0]), 32'(word_b));
                check_value({pos, " green pixel"},
                            32'(exp_sym[word_f][y*h_active+x][19:10]), 32'(word_g));
                check_value({pos, " red pixel"},
                            32'(exp_sym[word_f][y*h_active+x][29:20]), 32'(word_r));
                n_seen++;
            end
        end
    endtask

    // frame strobe spacing and the pixel count since frame start.
    always @(negedge clk_pixel) begin
        if (frame === 1'b1) begin
            if (frame_idx >= 0) begin
                check_value("frame period", 32'(frame_cycles), 32'(pix_cnt + 1));
            end
            frame_idx <= frame_idx + 1;
            pix_cnt   <= 0;
        end else begin
            pix_cnt <= pix_cnt + 1;
        end
    end

    // deserializer, a rising clock channel bit starts a word.
    always @(negedge clk_shift) begin
        if (arst_n && tmds_clk && !prev_clk) begin
            if (locked) begin
                check_value("bits per clock word", 32'd10, 32'(bit_cnt));
            end
            locked  = 1'b1;
            bit_cnt = 0;
            check_value("word boundary offset", 32'(bit_sample_ofs),
                        32'(int'($time % pixel_period)));
            word_f = frame_idx;
            // pix_cnt restarts on the falling edge after the frame edge.
            word_p = pix_cnt + 1 - word_latency;
            if (word_p < 0) begin
                word_p = word_p + frame_cycles;
                word_f = word_f - 1;
            end
        end
        if (locked && bit_cnt < 10) begin
            word_c = {tmds_clk, word_c[9:1]};
            word_b = {tmds_data[0], word_b[9:1]};
            word_g = {tmds_data[1], word_g[9:1]};
            word_r = {tmds_data[2], word_r[9:1]};
            bit_cnt++;
            if (bit_cnt == 10) begin
                check_word();
            end
        end
        prev_clk = tmds_clk;
    end

    initial begin
        arst_n  = 1'b0;
        wr_en   = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        read_trace();
        repeat (10) @(negedge clk_pixel);
        // release on the last shift edge before a pixel edge, so the
        // serializer phase starts on that pixel edge.
        repeat (5) @(negedge clk_shift);
        arst_n = 1'b1;
        wait_for_lock();
        wait_for_frame(0);
        issue_writes(0);
        wait_for_frame(1);
        // rewrites land after the active rows of frame 1 were read.
        wait_for_pix(200);
        issue_writes(1);
        wait_for_frame(3);
        check_value("expected pixels seen", 32'(n_exp), 32'(n_seen));
        $display("STATUS: PASS");
        $finish;
    end

endmodule

/* tests/video_trace.txt */
# W tag addr rgb : tag 0 written before frame 1, tag 1 during frame 1, rgb is RRGGBB hex
# E frame x y blue green red : expected 10-bit symbols in hex
W 0 0 000000
W 0 1 000000
W 0 16 FFFFFF
W 0 17 FFFFFF
W 0 32 010101
W 0 33 010101
W 0 48 0000FF
W 0 49 FF0100
W 0 64 01FF00
W 0 65 000101
W 0 80 FF0001
W 0 81 01FFFF
W 0 96 010000
W 0 97 0100FF
W 0 112 FFFF01
W 0 113 00FF00
W 1 32 000000
W 1 33 FFFFFF
W 1 80 FFFFFF
W 1 81 000000
E 1 0 0 100 100 100
E 1 1 0 3FF 3FF 3FF
E 1 0 1 200 200 200
E 1 1 1 0FF 0FF 0FF
E 1 0 2 1FF 1FF 1FF
E 1 1 2 300 300 300
E 1 0 3 200 100 100
E 1 1 3 3FF 1FF 0FF
E 1 0 4 100 200 1FF
E 1 1 4 1FF 1FF 100
E 1 0 5 1FF 100 200
E 1 1 5 200 0FF 1FF
E 1 0 6 100 100 1FF
E 1 1 6 0FF 3FF 300
E 1 0 7 1FF 200 200
E 1 1 7 100 0FF 3FF
E 2 0 2 100 100 100
E 2 1 2 0FF 0FF 0FF
E 2 0 5 200 200 200
E 2 1 5 3FF 3FF 3FF

/* verilog.f */
hw/video_timing_pkg.sv
hw/tmds_pkg.sv
hw/vga_gen.sv
hw/framebuffer.sv
hw/dvi_channel_mux.sv
hw/tmds_encoder.sv
hw/tmds_serializer.sv
hw/top_fb_dvi.sv
tests/tb_top_fb_dvi.sv
